//--- Makefile
SIM = obj_dir/Vtb_rr_storage_backend

$(SIM): all.f $(wildcard logic/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rr_storage_backend -f all.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- all.f
logic/rr_pkg.sv
logic/rr_csr.sv
logic/rr_record_packer.sv
logic/rr_writeback.sv
logic/rr_log_ram.sv
logic/rr_replay_unpacker.sv
logic/rr_storage_backend.sv
verification/rr_storage_backend_props.sv
verification/tb_rr_storage_backend.sv

//--- logic/rr_csr.sv
`timescale 1ns/10ps

module rr_csr (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          csr_wr,
  input  logic                          csr_rd,
  input  rr_pkg::rr_reg_e               csr_addr,
  input  logic [rr_pkg::RR_WORD_W-1:0]  csr_wdata,
  output logic [rr_pkg::RR_WORD_W-1:0]  csr_rdata,
  input  rr_pkg::rr_status_t            status,
  output rr_pkg::rr_cfg_t               cfg
);
  import rr_pkg::*;

  logic [RR_ADDR_W-1:0] base_q;
  logic [RR_ADDR_W:0]   size_q;
  rr_mode_e             mode_q;
  logic                 finish_q;
  logic                 start_q;
  logic [RR_BITS_W-1:0] recorded_q;
  logic [RR_WORD_W-1:0] rdata_d;

  // Register writes, CTRL bits 2 and 3 become one-cycle pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      base_q     <= '0;
      size_q     <= '0;
      mode_q     <= MODE_IDLE;
      finish_q   <= 1'b0;
      start_q    <= 1'b0;
      recorded_q <= '0;
    end else begin
      finish_q <= 1'b0;
      start_q  <= 1'b0;
      if (csr_wr) begin
        case (csr_addr)
          REG_BASE: base_q <= csr_wdata[RR_ADDR_W-1:0];
          REG_SIZE: size_q <= csr_wdata[RR_ADDR_W:0];
          REG_CTRL: begin
            // Code 3 is unused and parks the backend
            case (csr_wdata[1:0])
              2'd1:    mode_q <= MODE_RECORD;
              2'd2:    mode_q <= MODE_REPLAY;
              default: mode_q <= MODE_IDLE;
            endcase
            finish_q <= csr_wdata[2];
            start_q  <= csr_wdata[3];
          end
          default: ;
        endcase
      end
      // Snapshot of the recorded length for a later replay
      if (finish_q)
        recorded_q <= status.bits_written;
    end
  end

  // Read mux
  always_comb begin
    rdata_d = '0;
    case (csr_addr)
      REG_BASE: rdata_d[RR_ADDR_W-1:0] = base_q;
      REG_SIZE: rdata_d[RR_ADDR_W:0]   = size_q;
      REG_CTRL: rdata_d[1:0]           = mode_q;
      default: begin
        rdata_d[6:0]  = status.words_written;
        rdata_d[19:8] = status.bits_written;
        rdata_d[24]   = status.overflow;
        rdata_d[25]   = status.replay_done;
      end
    endcase
  end

  // Read data is valid one cycle after csr_rd
  always_ff @(posedge clk) begin
    if (rst)
      csr_rdata <= '0;
    else if (csr_rd)
      csr_rdata <= rdata_d;
  end

  assign cfg = '{base: base_q, size: size_q, mode: mode_q, finish: finish_q,
                 replay_start: start_q, recorded_bits: recorded_q};

endmodule

//--- logic/rr_log_ram.sv
`timescale 1ns/10ps

module rr_log_ram (
  input  logic                          clk,
  input  logic                          wr_en,
  input  logic [rr_pkg::RR_ADDR_W-1:0]  wr_addr,
  input  logic [rr_pkg::RR_WORD_W-1:0]  wr_data,
  input  logic                          rd_en,
  input  logic [rr_pkg::RR_ADDR_W-1:0]  rd_addr,
  output logic [rr_pkg::RR_WORD_W-1:0]  rd_data
);
  import rr_pkg::*;

  logic [RR_WORD_W-1:0] mem [2**RR_ADDR_W];

  // One write port, one registered read port
  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

endmodule

//--- logic/rr_pkg.sv
package rr_pkg;

  // Channel layout of one log unit
  localparam int RR_LOGB_CNT = 2;
  localparam int RR_LOGE_CNT = 2;
  localparam int RR_LOGB_W0  = 8;
  localparam int RR_LOGB_W1  = 12;

  // Widths of the datapath
  localparam int RR_UNIT_W = 24;
  localparam int RR_LEN_W  = 5;
  localparam int RR_WORD_W = 32;
  localparam int RR_ADDR_W = 6;
  localparam int RR_BITS_W = 12;

  // Bit buffer in packer and unpacker holds a full unit plus one word
  localparam int RR_BUF_W  = RR_UNIT_W + RR_WORD_W;
  localparam int RR_FILL_W = 6;

  // Unit data from the LSB: logb valid, loge valid, present logb payloads
  typedef struct packed {
    logic [RR_UNIT_W-1:0] data;
    logic [RR_LEN_W-1:0]  len;
  } rr_unit_t;

  typedef enum logic [1:0] {
    MODE_IDLE   = 2'd0,
    MODE_RECORD = 2'd1,
    MODE_REPLAY = 2'd2
  } rr_mode_e;

  typedef enum logic [1:0] {
    REG_BASE   = 2'd0,
    REG_SIZE   = 2'd1,
    REG_CTRL   = 2'd2,
    REG_STATUS = 2'd3
  } rr_reg_e;

  typedef struct packed {
    logic [RR_ADDR_W-1:0] base;
    logic [RR_ADDR_W:0]   size;
    rr_mode_e             mode;
    logic                 finish;
    logic                 replay_start;
    logic [RR_BITS_W-1:0] recorded_bits;
  } rr_cfg_t;

  typedef struct packed {
    logic [RR_ADDR_W:0]   words_written;
    logic [RR_BITS_W-1:0] bits_written;
    logic                 overflow;
    logic                 replay_done;
  } rr_status_t;

  // Unit length from the logb bitmap in the low bits
  function automatic logic [RR_LEN_W-1:0] rr_unit_len(input logic [RR_UNIT_W-1:0] bits);
    logic [RR_LEN_W-1:0] len;
    len = RR_LEN_W'(RR_LOGB_CNT + RR_LOGE_CNT);
    if (bits[0])
      len = len + RR_LEN_W'(RR_LOGB_W0);
    if (bits[1])
      len = len + RR_LEN_W'(RR_LOGB_W1);
    return len;
  endfunction

  // Clears the bits of a unit above its length
  function automatic logic [RR_UNIT_W-1:0] rr_unit_mask(input logic [RR_UNIT_W-1:0] data,
                                                        input logic [RR_LEN_W-1:0]  len);
    logic [RR_UNIT_W:0] ones;
    ones = {{RR_UNIT_W{1'b0}}, 1'b1} << len;
    ones = ones - 1'b1;
    return data & ones[RR_UNIT_W-1:0];
  endfunction

endpackage

//--- logic/rr_record_packer.sv
`timescale 1ns/10ps

module rr_record_packer (
  input  logic                          clk,
  input  logic                          rst,
  input  rr_pkg::rr_cfg_t               cfg,
  input  logic                          record_valid,
  output logic                          record_ready,
  input  rr_pkg::rr_unit_t              record_unit,
  input  logic                          overflow,
  output logic                          word_valid,
  output logic [rr_pkg::RR_WORD_W-1:0]  word,
  output logic [rr_pkg::RR_LEN_W-1:0]   unit_len_acc
);
  import rr_pkg::*;

  logic [RR_BUF_W-1:0]  acc_q;
  logic [RR_BUF_W-1:0]  acc_in;
  logic [RR_FILL_W-1:0] fill_q;
  logic [RR_FILL_W-1:0] fill_in;
  logic                 accept;

  // Held off during the finish pulse so the flush sees a stable fill
  assign record_ready = (cfg.mode == MODE_RECORD) && !overflow && !cfg.finish;
  assign accept       = record_valid && record_ready;

  // New unit lands right above the bits already packed
  always_comb begin
    acc_in  = acc_q | (RR_BUF_W'(rr_unit_mask(record_unit.data, record_unit.len)) << fill_q);
    fill_in = fill_q + RR_FILL_W'(record_unit.len);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      acc_q        <= '0;
      fill_q       <= '0;
      word_valid   <= 1'b0;
      unit_len_acc <= '0;
    end else begin
      word_valid   <= 1'b0;
      unit_len_acc <= '0;
      if (cfg.finish) begin
        // Partial word goes out, upper bits are already zero
        word_valid <= (fill_q != '0);
        acc_q      <= '0;
        fill_q     <= '0;
      end else if (accept) begin
        unit_len_acc <= record_unit.len;
        if (fill_in >= RR_FILL_W'(RR_WORD_W)) begin
          word_valid <= 1'b1;
          acc_q      <= acc_in >> RR_WORD_W;
          fill_q     <= fill_in - RR_FILL_W'(RR_WORD_W);
        end else begin
          acc_q  <= acc_in;
          fill_q <= fill_in;
        end
      end else if (cfg.mode != MODE_RECORD) begin
        // Leftovers outside record mode are dropped
        acc_q  <= '0;
        fill_q <= '0;
      end
    end
  end

  // Low word of whichever accumulator is being emitted
  always_ff @(posedge clk) begin
    if (cfg.finish)
      word <= acc_q[RR_WORD_W-1:0];
    else
      word <= acc_in[RR_WORD_W-1:0];
  end

endmodule

//--- logic/rr_replay_unpacker.sv
`timescale 1ns/10ps

module rr_replay_unpacker (
  input  logic                          clk,
  input  logic                          rst,
  input  rr_pkg::rr_cfg_t               cfg,
  output logic                          rd_en,
  output logic [rr_pkg::RR_ADDR_W-1:0]  rd_addr,
  input  logic [rr_pkg::RR_WORD_W-1:0]  rd_data,
  output logic                          replay_valid,
  input  logic                          replay_ready,
  output rr_pkg::rr_unit_t              replay_unit,
  output logic                          replay_done
);
  import rr_pkg::*;

  typedef enum logic [1:0] {
    UNP_IDLE,
    UNP_FILL,
    UNP_EMIT
  } unp_state_e;

  unp_state_e           state_q;
  rr_mode_e             mode_q;
  logic [RR_BUF_W-1:0]  bitbuf_q;
  logic [RR_BUF_W-1:0]  bitbuf_shift;
  logic [RR_BUF_W-1:0]  bitbuf_next;
  logic [RR_FILL_W-1:0] fill_q;
  logic [RR_FILL_W-1:0] fill_shift;
  logic [RR_FILL_W-1:0] fill_next;
  logic [RR_ADDR_W-1:0] rd_ptr_q;
  logic [RR_ADDR_W:0]   words_left_q;
  logic [RR_ADDR_W:0]   words_start;
  logic [RR_BITS_W:0]   words_need;
  logic [RR_BITS_W-1:0] bits_left_q;
  logic [RR_LEN_W-1:0]  cur_len;
  logic                 rd_pend_q;
  logic                 take;
  logic                 mode_chg;
  logic                 starved;

  // Length of the unit sitting at the bottom of the buffer
  assign cur_len  = rr_unit_len(bitbuf_q[RR_UNIT_W-1:0]);
  assign take     = replay_valid && replay_ready;
  assign mode_chg = cfg.mode != mode_q;

  // Words to fetch, never more than the buffer holds
  assign words_need  = ({1'b0, cfg.recorded_bits} + (RR_BITS_W+1)'(RR_WORD_W - 1))
                       >> $clog2(RR_WORD_W);
  assign words_start = (words_need > (RR_BITS_W+1)'(cfg.size)) ? cfg.size
                                                               : words_need[RR_ADDR_W:0];

  // Read only while a whole word still fits, one read in flight
  assign rd_addr = rd_ptr_q;
  assign rd_en   = (state_q != UNP_IDLE) && (words_left_q != '0) && !rd_pend_q &&
                   (fill_q <= RR_FILL_W'(RR_BUF_W - RR_WORD_W));

  // Nothing more to fetch and not enough bits for a unit
  assign starved = (words_left_q == '0) && !rd_pend_q && (fill_q < RR_FILL_W'(cur_len));

  // Consume the emitted unit, then append the arriving word
  always_comb begin
    bitbuf_shift = bitbuf_q;
    fill_shift   = fill_q;
    if (take) begin
      bitbuf_shift = bitbuf_q >> replay_unit.len;
      fill_shift   = fill_q - RR_FILL_W'(replay_unit.len);
    end
    bitbuf_next = bitbuf_shift;
    fill_next   = fill_shift;
    if (rd_pend_q) begin
      bitbuf_next = bitbuf_shift | (RR_BUF_W'(rd_data) << fill_shift);
      fill_next   = fill_shift + RR_FILL_W'(RR_WORD_W);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= UNP_IDLE;
      mode_q       <= MODE_IDLE;
      bitbuf_q     <= '0;
      fill_q       <= '0;
      rd_ptr_q     <= '0;
      words_left_q <= '0;
      bits_left_q  <= '0;
      rd_pend_q    <= 1'b0;
      replay_valid <= 1'b0;
      replay_done  <= 1'b0;
    end else begin
      mode_q    <= cfg.mode;
      rd_pend_q <= rd_en;
      bitbuf_q  <= bitbuf_next;
      fill_q    <= fill_next;
      if (rd_en) begin
        rd_ptr_q     <= rd_ptr_q + 1'b1;
        words_left_q <= words_left_q - 1'b1;
      end
      case (state_q)
        UNP_FILL: begin
          if ((bits_left_q == '0) || starved) begin
            state_q     <= UNP_IDLE;
            replay_done <= 1'b1;
          end else if (fill_q >= RR_FILL_W'(cur_len)) begin
            replay_valid <= 1'b1;
            state_q      <= UNP_EMIT;
          end
        end
        UNP_EMIT: begin
          if (take) begin
            replay_valid <= 1'b0;
            if (bits_left_q <= RR_BITS_W'(replay_unit.len)) begin
              // Last recorded unit
              bits_left_q <= '0;
              state_q     <= UNP_IDLE;
              replay_done <= 1'b1;
            end else begin
              bits_left_q <= bits_left_q - RR_BITS_W'(replay_unit.len);
              state_q     <= UNP_FILL;
            end
          end
        end
        default: ;
      endcase
      // Mode change aborts, a start in the same cycle still wins
      if (mode_chg) begin
        state_q      <= UNP_IDLE;
        replay_valid <= 1'b0;
        replay_done  <= 1'b0;
      end
      if (cfg.replay_start && (cfg.mode == MODE_REPLAY)) begin
        state_q      <= UNP_FILL;
        replay_valid <= 1'b0;
        replay_done  <= 1'b0;
        bitbuf_q     <= '0;
        fill_q       <= '0;
        rd_pend_q    <= 1'b0;
        rd_ptr_q     <= cfg.base;
        words_left_q <= words_start;
        bits_left_q  <= cfg.recorded_bits;
      end
    end
  end

  // Unit captured while filling stays put until the transfer
  always_ff @(posedge clk) begin
    if (state_q == UNP_FILL)
      replay_unit <= '{data: rr_unit_mask(bitbuf_q[RR_UNIT_W-1:0], cur_len), len: cur_len};
  end

endmodule

//--- logic/rr_storage_backend.sv
`timescale 1ns/10ps

module rr_storage_backend (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          csr_wr,
  input  logic                          csr_rd,
  input  rr_pkg::rr_reg_e               csr_addr,
  input  logic [rr_pkg::RR_WORD_W-1:0]  csr_wdata,
  output logic [rr_pkg::RR_WORD_W-1:0]  csr_rdata,
  input  logic                          record_valid,
  output logic                          record_ready,
  input  rr_pkg::rr_unit_t              record_unit,
  output logic                          replay_valid,
  input  logic                          replay_ready,
  output rr_pkg::rr_unit_t              replay_unit
);
  import rr_pkg::*;

  rr_cfg_t              cfg;
  rr_status_t           status;
  logic                 word_valid;
  logic [RR_WORD_W-1:0] word;
  logic [RR_LEN_W-1:0]  unit_len_acc;
  logic                 wr_en;
  logic [RR_ADDR_W-1:0] wr_addr;
  logic [RR_WORD_W-1:0] wr_data;
  logic                 rd_en;
  logic [RR_ADDR_W-1:0] rd_addr;
  logic [RR_WORD_W-1:0] rd_data;
  logic [RR_ADDR_W:0]   words_written;
  logic [RR_BITS_W-1:0] bits_written;
  logic                 overflow;
  logic                 replay_done;

  // Status gathered from the record and replay paths
  assign status = '{words_written: words_written, bits_written: bits_written,
                    overflow: overflow, replay_done: replay_done};

  rr_csr rr_csr_i (
    .clk(clk), .rst(rst), .csr_wr(csr_wr), .csr_rd(csr_rd), .csr_addr(csr_addr),
    .csr_wdata(csr_wdata), .csr_rdata(csr_rdata), .status(status), .cfg(cfg)
  );

  // Record path
  rr_record_packer rr_record_packer_i (
    .clk(clk), .rst(rst), .cfg(cfg), .record_valid(record_valid),
    .record_ready(record_ready), .record_unit(record_unit), .overflow(overflow),
    .word_valid(word_valid), .word(word), .unit_len_acc(unit_len_acc)
  );

  rr_writeback rr_writeback_i (
    .clk(clk), .rst(rst), .cfg(cfg), .word_valid(word_valid), .word(word),
    .unit_len_acc(unit_len_acc), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .words_written(words_written), .bits_written(bits_written), .overflow(overflow)
  );

  rr_log_ram rr_log_ram_i (
    .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  // Replay path
  rr_replay_unpacker rr_replay_unpacker_i (
    .clk(clk), .rst(rst), .cfg(cfg), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
    .replay_valid(replay_valid), .replay_ready(replay_ready), .replay_unit(replay_unit),
    .replay_done(replay_done)
  );

endmodule

//--- logic/rr_writeback.sv
`timescale 1ns/10ps

module rr_writeback (
  input  logic                          clk,
  input  logic                          rst,
  input  rr_pkg::rr_cfg_t               cfg,
  input  logic                          word_valid,
  input  logic [rr_pkg::RR_WORD_W-1:0]  word,
  input  logic [rr_pkg::RR_LEN_W-1:0]   unit_len_acc,
  output logic                          wr_en,
  output logic [rr_pkg::RR_ADDR_W-1:0]  wr_addr,
  output logic [rr_pkg::RR_WORD_W-1:0]  wr_data,
  output logic [rr_pkg::RR_ADDR_W:0]    words_written,
  output logic [rr_pkg::RR_BITS_W-1:0]  bits_written,
  output logic                          overflow
);
  import rr_pkg::*;

  rr_mode_e mode_q;
  logic     clear;
  logic     room;

  // Entering record mode starts a fresh log
  assign clear = (cfg.mode == MODE_RECORD) && (mode_q != MODE_RECORD);
  assign room  = words_written < cfg.size;

  // Address wraps around the 64-word RAM
  assign wr_en   = word_valid && room && !clear;
  assign wr_addr = cfg.base + words_written[RR_ADDR_W-1:0];
  assign wr_data = word;

  always_ff @(posedge clk) begin
    if (rst) begin
      mode_q        <= MODE_IDLE;
      words_written <= '0;
      bits_written  <= '0;
      overflow      <= 1'b0;
    end else begin
      mode_q <= cfg.mode;
      if (clear) begin
        words_written <= '0;
        bits_written  <= '0;
        overflow      <= 1'b0;
      end else begin
        bits_written <= bits_written + RR_BITS_W'(unit_len_acc);
        if (wr_en)
          words_written <= words_written + 1'b1;
        else if (word_valid)
          overflow <= 1'b1;  // buffer full, word dropped
      end
    end
  end

endmodule

//--- verification/rr_storage_backend_props.sv
`timescale 1ns/10ps

module rr_storage_backend_props (
  input  logic                          clk,
  input  logic                          rst,
  input  rr_pkg::rr_cfg_t               cfg,
  input  logic                          record_ready,
  input  logic                          replay_valid,
  input  logic                          replay_ready,
  input  rr_pkg::rr_unit_t              replay_unit,
  input  logic                          wr_en,
  input  logic [rr_pkg::RR_ADDR_W-1:0]  wr_addr
);
  import rr_pkg::*;

  logic [RR_ADDR_W-1:0] wr_offset;

  // Offset into the buffer, wraps like the RAM address
  assign wr_offset = wr_addr - cfg.base;

  // Stalled unit holds until the transfer
  replay_stable: assert property (@(posedge clk) disable iff (rst)
    (replay_valid && !replay_ready) |=> (replay_valid && $stable(replay_unit)))
    else $error("replay_unit changed or dropped while stalled");

  // No record traffic outside record mode
  record_mode_only: assert property (@(posedge clk) disable iff (rst)
    (cfg.mode != MODE_RECORD) |-> !record_ready)
    else $error("record_ready high outside record mode");

  // Writes stay inside base .. base + size
  write_in_bounds: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> ({1'b0, wr_offset} < cfg.size))
    else $error("RAM write outside the log buffer");

endmodule

bind rr_storage_backend rr_storage_backend_props rr_storage_backend_props_i (
  .clk(clk), .rst(rst), .cfg(cfg), .record_ready(record_ready),
  .replay_valid(replay_valid), .replay_ready(replay_ready), .replay_unit(replay_unit),
  .wr_en(wr_en), .wr_addr(wr_addr)
);

//--- verification/tb_rr_storage_backend.sv
`timescale 1ns/10ps

module tb_rr_storage_backend;
  import rr_pkg::*;

  // Longest test is a 30-unit replay under random ready, well under 2000 cycles in all
  localparam int MAX_CYCLES = 20000;

  logic                 clk;
  logic                 rst;
  logic                 csr_wr;
  logic                 csr_rd;
  rr_reg_e              csr_addr;
  logic [RR_WORD_W-1:0] csr_wdata;
  logic [RR_WORD_W-1:0] csr_rdata;
  logic                 record_valid;
  logic                 record_ready;
  rr_unit_t             record_unit;
  logic                 replay_valid;
  logic                 replay_ready;
  rr_unit_t             replay_unit;

  integer   seed = 32'h4587;
  int       errors;
  int       tests;
  int       cycle_count;
  // Units accepted on the record stream, and units due on the replay stream
  rr_unit_t sent_q[$];
  rr_unit_t exp_q[$];

  rr_storage_backend rr_storage_backend_i (
    .clk(clk), .rst(rst), .csr_wr(csr_wr), .csr_rd(csr_rd), .csr_addr(csr_addr),
    .csr_wdata(csr_wdata), .csr_rdata(csr_rdata), .record_valid(record_valid),
    .record_ready(record_ready), .record_unit(record_unit), .replay_valid(replay_valid),
    .replay_ready(replay_ready), .replay_unit(replay_unit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  // Bitmap bits plus the width of each present logb payload
  function automatic int unit_bits(input logic [1:0] logb_valid);
    int n;
    n = 4;
    if (logb_valid[0])
      n = n + 8;
    if (logb_valid[1])
      n = n + 12;
    return n;
  endfunction

  // Random unit, bits above its length cleared
  task automatic next_unit(output rr_unit_t u);
    logic [31:0] r;
    int          len;
    r      = $random(seed);
    len    = unit_bits(r[1:0]);
    u.len  = RR_LEN_W'(len);
    u.data = r[RR_UNIT_W-1:0] & ((24'd1 << len) - 24'd1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("CHECK FAILED t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
  endtask

  task automatic log_test_result(input string name, input int err_before);
    tests++;
    $display("Test %s finished with %0d errors", name, errors - err_before);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic write_reg(input rr_reg_e addr, input logic [31:0] data);
    @(posedge clk);
    csr_wr    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(posedge clk);
    csr_wr <= 1'b0;
  endtask

  task automatic read_reg(input rr_reg_e addr, output logic [31:0] data);
    @(posedge clk);
    csr_rd   <= 1'b1;
    csr_addr <= addr;
    @(posedge clk);
    csr_rd <= 1'b0;
    // rdata registered on the edge that saw csr_rd
    @(negedge clk);
    data = csr_rdata;
  endtask

  // Offers units until max_units transfer or record_ready drops
  task automatic send_units(input int max_units, output int sent);
    rr_unit_t u;
    sent = 0;
    next_unit(u);
    record_unit  <= u;
    record_valid <= 1'b1;
    while (sent < max_units) begin
      @(posedge clk);
      if (record_valid && record_ready) begin
        sent_q.push_back(record_unit);
        sent++;
        next_unit(u);
        record_unit <= u;
      end else if (!record_ready && sent > 0) begin
        break;
      end
    end
    record_valid <= 1'b0;
  endtask

  // Takes every unit in exp_q off the replay stream, then watches for extras
  task automatic collect_replay(input bit random_ready);
    int          idx;
    int          extra;
    logic [31:0] r;
    idx   = 0;
    extra = 0;
    replay_ready <= 1'b1;
    while (idx < exp_q.size()) begin
      @(posedge clk);
      if (replay_valid && replay_ready) begin
        if (replay_unit.len != exp_q[idx].len)
          report_mismatch("replay_unit.len", replay_unit.len, exp_q[idx].len);
        if (replay_unit.data != exp_q[idx].data)
          report_mismatch("replay_unit.data", replay_unit.data, exp_q[idx].data);
        idx++;
      end
      if (random_ready) begin
        r = $random(seed);
        replay_ready <= r[0];
      end
    end
    replay_ready <= 1'b1;
    repeat (16) begin
      @(posedge clk);
      if (replay_valid && replay_ready)
        extra++;
    end
    replay_ready <= 1'b0;
    if (extra != 0) begin
      errors++;
      $display("Replay sent %0d units beyond the recorded ones", extra);
    end
  endtask

  task automatic check_replay_done();
    logic [31:0] rd;
    read_reg(REG_STATUS, rd);
    if (rd[25] != 1'b1)
      report_mismatch("replay_done", rd[25], 1);
  endtask

  task automatic registers_readback();
    logic [31:0] rd;
    int          err0;
    err0 = errors;
    read_reg(REG_STATUS, rd);
    if (rd != 32'd0)
      report_mismatch("status", rd, 0);
    write_reg(REG_BASE, 32'd5);
    write_reg(REG_SIZE, 32'd32);
    read_reg(REG_BASE, rd);
    if (rd != 32'd5)
      report_mismatch("base", rd, 5);
    read_reg(REG_SIZE, rd);
    if (rd != 32'd32)
      report_mismatch("size", rd, 32);
    log_test_result("registers_readback", err0);
  endtask

  task automatic record_thirty_units();
    logic [31:0] rd;
    int          err0;
    int          sent;
    int          sum;
    err0 = errors;
    sent_q.delete();
    write_reg(REG_CTRL, 32'h1);
    wait_cycles(3);
    send_units(30, sent);
    if (sent != 30)
      report_mismatch("units accepted", sent, 30);
    sum = 0;
    foreach (sent_q[i])
      sum = sum + int'(sent_q[i].len);
    // Let the last length reach the bit counter, then flush
    wait_cycles(4);
    write_reg(REG_CTRL, 32'h5);
    wait_cycles(4);
    read_reg(REG_STATUS, rd);
    if (rd[19:8] != 12'(sum))
      report_mismatch("bits_written", rd[19:8], sum);
    if (rd[6:0] != 7'((sum + 31) / 32))
      report_mismatch("words_written", rd[6:0], (sum + 31) / 32);
    if (rd[24] != 1'b0)
      report_mismatch("overflow", rd[24], 0);
    exp_q = sent_q;
    log_test_result("record_thirty_units", err0);
  endtask

  task automatic replay_with_ready_high();
    int err0;
    err0 = errors;
    write_reg(REG_CTRL, 32'hA);
    collect_replay(1'b0);
    check_replay_done();
    log_test_result("replay_with_ready_high", err0);
  endtask

  task automatic replay_with_random_ready();
    int err0;
    err0 = errors;
    write_reg(REG_CTRL, 32'hA);
    collect_replay(1'b1);
    check_replay_done();
    log_test_result("replay_with_random_ready", err0);
  endtask

  task automatic overflow_and_partial_replay();
    logic [31:0] rd;
    int          err0;
    int          sent;
    int          total;
    err0 = errors;
    sent_q.delete();
    write_reg(REG_SIZE, 32'd2);
    write_reg(REG_CTRL, 32'h1);
    wait_cycles(3);
    send_units(64, sent);
    if (sent >= 64) begin
      errors++;
      $display("record_ready stayed high after %0d units with a two-word buffer", sent);
    end
    wait_cycles(4);
    read_reg(REG_STATUS, rd);
    if (rd[24] != 1'b1)
      report_mismatch("overflow", rd[24], 1);
    if (rd[6:0] != 7'd2)
      report_mismatch("words_written", rd[6:0], 2);
    // Only units that end inside the two stored words come back
    exp_q.delete();
    total = 0;
    foreach (sent_q[i]) begin
      total = total + int'(sent_q[i].len);
      if (total <= 64)
        exp_q.push_back(sent_q[i]);
    end
    write_reg(REG_CTRL, 32'h5);
    wait_cycles(4);
    write_reg(REG_CTRL, 32'hA);
    collect_replay(1'b0);
    check_replay_done();
    log_test_result("overflow_and_partial_replay", err0);
  endtask

  initial begin
    errors = 0;
    tests  = 0;
    rst          <= 1'b1;
    csr_wr       <= 1'b0;
    csr_rd       <= 1'b0;
    csr_addr     <= REG_BASE;
    csr_wdata    <= '0;
    record_valid <= 1'b0;
    record_unit  <= '0;
    replay_ready <= 1'b0;
    wait_cycles(8);
    rst <= 1'b0;
    registers_readback();
    record_thirty_units();
    replay_with_ready_high();
    replay_with_random_ready();
    overflow_and_partial_replay();
    wait_cycles(4);
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
